//--- hdl/driver_config.svh
`ifndef DRIVER_CONFIG_SVH
`define DRIVER_CONFIG_SVH

// Memory and data widths
`define DRV_MEM_BW 128
`define DRV_ACT_W 8
`define DRV_MASK_W 16
`define DRV_MASKS_PER_HALF 8

// One bank per filter position
`define DRV_N_FX 2
`define DRV_N_FY 3

`define DRV_ADDR_W 14

// Lines 0 and 1 come in through loading
`define DRV_FETCH_START 2

`endif

//--- hdl/driver_pkg.sv
`default_nettype none
`include "driver_config.svh"

package driver_pkg;

    typedef logic [`DRV_MEM_BW-1:0] line_t;
    typedef logic [`DRV_MASK_W-1:0] mask_t;
    typedef logic [`DRV_ACT_W-1:0] act_t;

    typedef logic [$clog2(`DRV_N_FX)-1:0] fx_t;
    typedef logic [$clog2(`DRV_N_FY)-1:0] fy_t;
    typedef logic [`DRV_ADDR_W-1:0] addr_t;

    // Ones count of a mask word, 0 to 16
    typedef logic [$clog2(`DRV_MASK_W+1)-1:0] cnt_t;
    // Bytes used from the lower line
    typedef logic [$clog2(`DRV_MEM_BW/`DRV_ACT_W)-1:0] keep_t;
    typedef logic [$clog2(`DRV_MEM_BW/`DRV_ACT_W+1)-1:0] shamt_t;

    typedef enum logic [2:0] {
        IDLE,
        SELECT,
        SHIFT,
        FETCH,
        SHIFT_REST
    } state_t;

endpackage

`default_nettype wire

//--- hdl/mask_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "driver_config.svh"

module mask_store (
    input  logic              clk,
    input  logic              arst_n_in,
    input  logic              load_en,
    input  logic              load_half,
    input  driver_pkg::fx_t   load_fx,
    input  driver_pkg::fy_t   load_fy,
    input  driver_pkg::line_t masks_in,
    input  driver_pkg::fx_t   sel_fx,
    input  driver_pkg::fy_t   sel_fy,
    input  logic              pop_mask,
    output driver_pkg::mask_t head_mask
);
    import driver_pkg::*;

    localparam int HALF = `DRV_MASKS_PER_HALF;
    localparam int DEPTH = 2 * HALF;

    mask_t queue [`DRV_N_FX][`DRV_N_FY][DEPTH];
    mask_t in_words [HALF];

    // First word in the top bits of the line
    always_comb begin
        for (int i = 0; i < HALF; i++) begin
            in_words[i] = masks_in[`DRV_MEM_BW-1-i*`DRV_MASK_W -: `DRV_MASK_W];
        end
    end

    always_ff @(posedge clk or negedge arst_n_in) begin
        if (!arst_n_in) begin
            for (int x = 0; x < `DRV_N_FX; x++) begin
                for (int y = 0; y < `DRV_N_FY; y++) begin
                    for (int w = 0; w < DEPTH; w++) begin
                        queue[x][y][w] <= '0;
                    end
                end
            end
        end else if (load_en) begin
            for (int i = 0; i < HALF; i++) begin
                queue[load_fx][load_fy][(load_half ? HALF : 0) + i] <= in_words[i];
            end
        end else if (pop_mask) begin
            // Move toward the head, zero enters at the tail
            for (int w = 0; w < DEPTH - 1; w++) begin
                queue[sel_fx][sel_fy][w] <= queue[sel_fx][sel_fy][w+1];
            end
            queue[sel_fx][sel_fy][DEPTH-1] <= '0;
        end
    end

    assign head_mask = queue[sel_fx][sel_fy][0];

endmodule

`default_nettype wire

//--- hdl/encoded_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "driver_config.svh"

module encoded_store (
    input  logic               clk,
    input  logic               arst_n_in,
    input  logic               load_en,
    input  logic               load_half,
    input  driver_pkg::fx_t    load_fx,
    input  driver_pkg::fy_t    load_fy,
    input  driver_pkg::line_t  encoded_in,
    input  driver_pkg::fx_t    sel_fx,
    input  driver_pkg::fy_t    sel_fy,
    input  logic               shift_en,
    input  driver_pkg::shamt_t shift_amt,
    input  logic               refill,
    output driver_pkg::act_t [2*`DRV_MEM_BW/`DRV_ACT_W-1:0] window
);
    import driver_pkg::*;

    localparam int LB = `DRV_MEM_BW / `DRV_ACT_W;

    // Byte 0 is the oldest byte of the stream
    act_t [2*LB-1:0] win [`DRV_N_FX][`DRV_N_FY];
    act_t [LB-1:0] in_bytes;
    act_t [2*LB-1:0] shifted;

    // Most significant byte of the line becomes byte 0
    always_comb begin
        for (int i = 0; i < LB; i++) begin
            in_bytes[i] = encoded_in[`DRV_MEM_BW-1-i*`DRV_ACT_W -: `DRV_ACT_W];
        end
    end

    // Zeros enter at the top byte
    assign shifted = win[sel_fx][sel_fy] >> (shift_amt * `DRV_ACT_W);

    always_ff @(posedge clk or negedge arst_n_in) begin
        if (!arst_n_in) begin
            for (int x = 0; x < `DRV_N_FX; x++) begin
                for (int y = 0; y < `DRV_N_FY; y++) begin
                    win[x][y] <= '0;
                end
            end
        end else if (load_en) begin
            if (load_half) begin
                win[load_fx][load_fy][2*LB-1:LB] <= in_bytes;
            end else begin
                win[load_fx][load_fy][LB-1:0] <= in_bytes;
            end
        end else if (shift_en) begin
            win[sel_fx][sel_fy] <= shifted;
        end else if (refill) begin
            // Fetched line goes behind what is left
            win[sel_fx][sel_fy][2*LB-1:LB] <= in_bytes;
        end
    end

    assign window = win[sel_fx][sel_fy];

endmodule

`default_nettype wire

//--- hdl/act_compactor.sv
`timescale 1ns/1ps
`default_nettype none
`include "driver_config.svh"

module act_compactor (
    input  logic              clk,
    input  logic              arst_n_in,
    input  logic              capture,
    input  driver_pkg::mask_t head_mask,
    input  driver_pkg::act_t [2*`DRV_MEM_BW/`DRV_ACT_W-1:0] window,
    output driver_pkg::mask_t mask_out,
    output driver_pkg::line_t encoded_out,
    output driver_pkg::cnt_t  ones_cnt
);
    import driver_pkg::*;

    localparam int LB = `DRV_MEM_BW / `DRV_ACT_W;

    cnt_t  count;
    line_t compact;

    always_comb begin
        count = '0;
        for (int i = 0; i < `DRV_MASK_W; i++) begin
            count = count + cnt_t'(head_mask[i]);
        end
    end

    // First count bytes, left-aligned, zeros after them
    always_comb begin
        for (int i = 0; i < LB; i++) begin
            compact[`DRV_MEM_BW-1-i*`DRV_ACT_W -: `DRV_ACT_W] = (i < count) ? window[i] : '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n_in) begin
        if (!arst_n_in) begin
            mask_out <= '0;
            encoded_out <= '0;
            ones_cnt <= '0;
        end else if (capture) begin
            mask_out <= head_mask;
            encoded_out <= compact;
            ones_cnt <= count;
        end
    end

endmodule

`default_nettype wire

//--- hdl/driver_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "driver_config.svh"

module driver_ctrl (
    input  logic               clk,
    input  logic               arst_n_in,
    input  logic               start,
    input  logic               clear_counters,
    input  driver_pkg::fx_t    fx,
    input  driver_pkg::fy_t    fy,
    input  driver_pkg::addr_t  base_addr,
    input  driver_pkg::cnt_t   ones_cnt,
    output driver_pkg::fx_t    sel_fx,
    output driver_pkg::fy_t    sel_fy,
    output logic               capture,
    output logic               pop_mask,
    output logic               shift_en,
    output logic               refill,
    output logic               ready,
    output logic               fetch_req,
    output driver_pkg::shamt_t shift_amt,
    output driver_pkg::addr_t  fetch_addr
);
    import driver_pkg::*;

    localparam int LB = `DRV_MEM_BW / `DRV_ACT_W;

    state_t state;
    state_t state_nx;
    addr_t  base_q;
    cnt_t   rest_q;
    keep_t  keep [`DRV_N_FX][`DRV_N_FY];
    addr_t  fetch_cnt [`DRV_N_FX][`DRV_N_FY];
    keep_t  keep_sel;
    shamt_t room;
    shamt_t keep_sum;
    logic   fetch_need;

    // Bytes left in the lower line of the selected bank
    assign keep_sel = keep[sel_fx][sel_fy];
    assign room = shamt_t'(LB) - shamt_t'(keep_sel);
    assign fetch_need = (ones_cnt != '0) && (ones_cnt >= room);
    assign keep_sum = shamt_t'(keep_sel) + shift_amt;
    assign fetch_addr = base_q + fetch_cnt[sel_fx][sel_fy];

    always_comb begin
        state_nx = state;
        capture = 1'b0;
        pop_mask = 1'b0;
        shift_en = 1'b0;
        shift_amt = '0;
        refill = 1'b0;
        ready = 1'b0;
        fetch_req = 1'b0;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nx = SELECT;
                end
            end
            SELECT: begin
                capture = 1'b1;
                state_nx = SHIFT;
            end
            SHIFT: begin
                ready = 1'b1;
                pop_mask = 1'b1;
                shift_en = (ones_cnt != '0);
                // Stop at the line end when the step crosses it
                shift_amt = fetch_need ? room : shamt_t'(ones_cnt);
                fetch_req = fetch_need;
                state_nx = fetch_need ? FETCH : IDLE;
            end
            FETCH: begin
                refill = 1'b1;
                state_nx = (rest_q != '0) ? SHIFT_REST : IDLE;
            end
            SHIFT_REST: begin
                shift_en = 1'b1;
                shift_amt = shamt_t'(rest_q);
                state_nx = IDLE;
            end
            default: begin
                state_nx = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_in) begin
        if (!arst_n_in) begin
            state <= IDLE;
            sel_fx <= '0;
            sel_fy <= '0;
            base_q <= '0;
            rest_q <= '0;
        end else begin
            state <= state_nx;
            if (state == IDLE && start) begin
                sel_fx <= fx;
                sel_fy <= fy;
                base_q <= base_addr;
            end
            if (state == SHIFT && fetch_need) begin
                rest_q <= ones_cnt - cnt_t'(room);
            end
        end
    end

    // Per-bank consumption and fetch counters
    always_ff @(posedge clk or negedge arst_n_in) begin
        if (!arst_n_in) begin
            for (int x = 0; x < `DRV_N_FX; x++) begin
                for (int y = 0; y < `DRV_N_FY; y++) begin
                    keep[x][y] <= '0;
                    fetch_cnt[x][y] <= addr_t'(`DRV_FETCH_START);
                end
            end
        end else if (state == IDLE && clear_counters) begin
            for (int x = 0; x < `DRV_N_FX; x++) begin
                for (int y = 0; y < `DRV_N_FY; y++) begin
                    keep[x][y] <= '0;
                    fetch_cnt[x][y] <= addr_t'(`DRV_FETCH_START);
                end
            end
        end else if (shift_en) begin
            keep[sel_fx][sel_fy] <= keep_t'(keep_sum);
            // Lower line used up, next fetch reads the following line
            if (keep_sum >= shamt_t'(LB)) begin
                fetch_cnt[sel_fx][sel_fy] <= fetch_cnt[sel_fx][sel_fy] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/sparse_act_driver.sv
`timescale 1ns/1ps
`default_nettype none
`include "driver_config.svh"

module sparse_act_driver (
    input  logic              clk,
    input  logic              arst_n_in,
    input  logic              load_en,
    input  driver_pkg::fx_t   load_fx,
    input  driver_pkg::fy_t   load_fy,
    input  logic              load_half,
    input  driver_pkg::line_t masks_in,
    input  driver_pkg::line_t encoded_in,
    input  logic              start,
    input  logic              clear_counters,
    input  driver_pkg::fx_t   fx,
    input  driver_pkg::fy_t   fy,
    input  driver_pkg::addr_t base_addr,
    output logic              ready,
    output logic              fetch_req,
    output driver_pkg::addr_t fetch_addr,
    output driver_pkg::mask_t mask_out,
    output driver_pkg::line_t encoded_out
);
    import driver_pkg::*;

    fx_t    sel_fx;
    fy_t    sel_fy;
    logic   capture;
    logic   pop_mask;
    logic   shift_en;
    logic   refill;
    shamt_t shift_amt;
    cnt_t   ones_cnt;
    mask_t  head_mask;
    act_t [2*`DRV_MEM_BW/`DRV_ACT_W-1:0] window;

    mask_store u_mask_store (
        .clk       (clk),
        .arst_n_in (arst_n_in),
        .load_en   (load_en),
        .load_half (load_half),
        .load_fx   (load_fx),
        .load_fy   (load_fy),
        .masks_in  (masks_in),
        .sel_fx    (sel_fx),
        .sel_fy    (sel_fy),
        .pop_mask  (pop_mask),
        .head_mask (head_mask)
    );

    encoded_store u_encoded_store (
        .clk        (clk),
        .arst_n_in  (arst_n_in),
        .load_en    (load_en),
        .load_half  (load_half),
        .load_fx    (load_fx),
        .load_fy    (load_fy),
        .encoded_in (encoded_in),
        .sel_fx     (sel_fx),
        .sel_fy     (sel_fy),
        .shift_en   (shift_en),
        .shift_amt  (shift_amt),
        .refill     (refill),
        .window     (window)
    );

    act_compactor u_act_compactor (
        .clk         (clk),
        .arst_n_in   (arst_n_in),
        .capture     (capture),
        .head_mask   (head_mask),
        .window      (window),
        .mask_out    (mask_out),
        .encoded_out (encoded_out),
        .ones_cnt    (ones_cnt)
    );

    driver_ctrl u_driver_ctrl (
        .clk            (clk),
        .arst_n_in      (arst_n_in),
        .start          (start),
        .clear_counters (clear_counters),
        .fx             (fx),
        .fy             (fy),
        .base_addr      (base_addr),
        .ones_cnt       (ones_cnt),
        .sel_fx         (sel_fx),
        .sel_fy         (sel_fy),
        .capture        (capture),
        .pop_mask       (pop_mask),
        .shift_en       (shift_en),
        .refill         (refill),
        .ready          (ready),
        .fetch_req      (fetch_req),
        .shift_amt      (shift_amt),
        .fetch_addr     (fetch_addr)
    );

endmodule

`default_nettype wire

//--- sim/sparse_act_driver_sva.sv
`timescale 1ns/1ps
`default_nettype none

module driver_ctrl_sva (
    input logic               clk,
    input logic               arst_n_in,
    input logic               ready,
    input logic               fetch_req,
    input logic               capture,
    input logic               pop_mask,
    input logic               shift_en,
    input logic               refill,
    input driver_pkg::state_t state
);
    import driver_pkg::*;

    int fail_count = 0;

    ready_single: assert property (
        @(posedge clk) disable iff (!arst_n_in) ready |=> !ready
    ) else begin
        fail_count++;
        $error("ready stayed high for two cycles");
    end

    // Memory answers in the cycle right after the request
    fetch_then_refill: assert property (
        @(posedge clk) disable iff (!arst_n_in) fetch_req |=> state == FETCH
    ) else begin
        fail_count++;
        $error("fetch_req not followed by the FETCH state");
    end

    quiet_in_reset: assert property (
        @(posedge clk) !arst_n_in |->
            !(ready || fetch_req || capture || pop_mask || shift_en || refill)
    ) else begin
        fail_count++;
        $error("strobe high during reset");
    end

endmodule

bind driver_ctrl driver_ctrl_sva u_driver_ctrl_sva (
    .clk       (clk),
    .arst_n_in (arst_n_in),
    .ready     (ready),
    .fetch_req (fetch_req),
    .capture   (capture),
    .pop_mask  (pop_mask),
    .shift_en  (shift_en),
    .refill    (refill),
    .state     (state)
);

`default_nettype wire

//--- sim/tb_sparse_act_driver.sv
`timescale 1ns/1ps
`default_nettype none
`include "driver_config.svh"

module tb_sparse_act_driver;
    import driver_pkg::*;

    localparam int N_BANKS = `DRV_N_FX * `DRV_N_FY;
    localparam int LB = `DRV_MEM_BW / `DRV_ACT_W;
    localparam int DEPTH = 2 * `DRV_MASKS_PER_HALF;

    logic  clk;
    logic  arst_n_in;
    logic  load_en;
    fx_t   load_fx;
    fy_t   load_fy;
    logic  load_half;
    line_t masks_in;
    line_t encoded_in;
    line_t load_data;
    line_t mem_data = '0;
    logic  start;
    logic  clear_counters;
    fx_t   fx;
    fy_t   fy;
    addr_t base_addr;
    logic  ready;
    logic  fetch_req;
    addr_t fetch_addr;
    mask_t mask_out;
    line_t encoded_out;

    // Reference model, one byte stream and one mask queue per bank
    act_t  ref_stream [N_BANKS][$];
    mask_t ref_masks [N_BANKS][$];
    int    ref_keep [N_BANKS];
    addr_t ref_fcnt [N_BANKS];
    addr_t bank_base [N_BANKS];
    line_t mem [addr_t];
    logic [15:0] lfsr_state = 16'd8;
    int    step_bank = 0;
    int    starts_issued = 0;
    int    readies_seen = 0;
    logic  fetch_due = 1'b0;
    addr_t due_addr = '0;

    // Loader and memory share the line input
    assign encoded_in = load_en ? load_data : mem_data;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    sparse_act_driver u_sparse_act_driver (
        .clk            (clk),
        .arst_n_in      (arst_n_in),
        .load_en        (load_en),
        .load_fx        (load_fx),
        .load_fy        (load_fy),
        .load_half      (load_half),
        .masks_in       (masks_in),
        .encoded_in     (encoded_in),
        .start          (start),
        .clear_counters (clear_counters),
        .fx             (fx),
        .fy             (fy),
        .base_addr      (base_addr),
        .ready          (ready),
        .fetch_req      (fetch_req),
        .fetch_addr     (fetch_addr),
        .mask_out       (mask_out),
        .encoded_out    (encoded_out)
    );

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic line_t random_line(int bits);
        line_t val;
        val = '0;
        for (int i = 0; i < bits; i++) begin
            val = {val[`DRV_MEM_BW-2:0], lfsr_bit()};
        end
        return val;
    endfunction

    // Lines appear on first use
    function automatic line_t mem_line(addr_t addr);
        if (!mem.exists(addr)) begin
            mem[addr] = random_line(`DRV_MEM_BW);
        end
        return mem[addr];
    endfunction

    function automatic void push_line(int b, line_t line);
        for (int i = 0; i < LB; i++) begin
            ref_stream[b].push_back(line[`DRV_MEM_BW-1-i*`DRV_ACT_W -: `DRV_ACT_W]);
        end
    endfunction

    function automatic void ref_step(int b, output mask_t exp_mask, output line_t exp_line,
                                     output logic exp_fetch, output addr_t exp_addr);
        int n;
        n = 0;
        exp_line = '0;
        exp_addr = '0;
        exp_mask = '0;
        if (ref_masks[b].size() > 0) begin
            exp_mask = ref_masks[b].pop_front();
        end
        for (int i = 0; i < `DRV_MASK_W; i++) begin
            n = n + int'(exp_mask[i]);
        end
        for (int i = 0; i < n; i++) begin
            exp_line[`DRV_MEM_BW-1-i*`DRV_ACT_W -: `DRV_ACT_W] = ref_stream[b].pop_front();
        end
        // Lower line used up, next line of this bank joins the stream
        exp_fetch = (n != 0) && (ref_keep[b] + n >= LB);
        if (exp_fetch) begin
            exp_addr = bank_base[b] + ref_fcnt[b];
            push_line(b, mem_line(exp_addr));
            ref_fcnt[b] = ref_fcnt[b] + 1'b1;
        end
        ref_keep[b] = (ref_keep[b] + n) % LB;
    endfunction

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_run(string msg);
        $display("%s at time %0t", msg, $time);
        stop_run();
    endtask

    task automatic report_mismatch(string msg);
        $display("mismatch at time %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_line(line_t got, line_t exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_mask(mask_t got, mask_t exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_addr(addr_t got, addr_t exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    // Compare process and memory model
    always @(negedge clk) begin : compare_proc
        mask_t exp_mask;
        line_t exp_line;
        logic  exp_fetch;
        addr_t exp_addr;
        if (fetch_due) begin
            mem_data = mem_line(due_addr);
            fetch_due = 1'b0;
        end
        if (arst_n_in && ready) begin
            if (readies_seen >= starts_issued) begin
                abort_run("ready pulsed without a start");
            end
            readies_seen++;
            ref_step(step_bank, exp_mask, exp_line, exp_fetch, exp_addr);
            check_mask(mask_out, exp_mask, "mask_out");
            check_line(encoded_out, exp_line, "encoded_out");
            check_bit(fetch_req, exp_fetch, "fetch_req");
            if (exp_fetch) begin
                check_addr(fetch_addr, exp_addr, "fetch_addr");
                fetch_due = 1'b1;
                due_addr = fetch_addr;
            end
        end else if (fetch_req) begin
            abort_run("fetch_req came outside the ready cycle");
        end
    end

    // Controller assertions
    always @(negedge clk) begin
        if (u_sparse_act_driver.u_driver_ctrl.u_driver_ctrl_sva.fail_count != 0) begin
            abort_run("controller assertion failed");
        end
    end

    task automatic load_bank(int b, logic full_first);
        mask_t words [DEPTH];
        line_t lines [2];
        ref_masks[b].delete();
        ref_stream[b].delete();
        for (int w = 0; w < DEPTH; w++) begin
            words[w] = mask_t'(random_line(`DRV_MASK_W));
        end
        if (full_first) begin
            words[0] = '1;
        end
        for (int w = 0; w < DEPTH; w++) begin
            ref_masks[b].push_back(words[w]);
        end
        for (int h = 0; h < 2; h++) begin
            lines[h] = random_line(`DRV_MEM_BW);
            push_line(b, lines[h]);
        end
        for (int h = 0; h < 2; h++) begin
            load_fx = fx_t'(b / `DRV_N_FY);
            load_fy = fy_t'(b % `DRV_N_FY);
            load_half = h[0];
            for (int i = 0; i < `DRV_MASKS_PER_HALF; i++) begin
                masks_in[`DRV_MEM_BW-1-i*`DRV_MASK_W -: `DRV_MASK_W] =
                    words[h*`DRV_MASKS_PER_HALF + i];
            end
            load_data = lines[h];
            load_en = 1'b1;
            @(negedge clk);
        end
        load_en = 1'b0;
    endtask

    task automatic clear_all();
        clear_counters = 1'b1;
        @(negedge clk);
        clear_counters = 1'b0;
        for (int b = 0; b < N_BANKS; b++) begin
            ref_keep[b] = 0;
            ref_fcnt[b] = addr_t'(`DRV_FETCH_START);
        end
    endtask

    task automatic run_step(int b);
        int cycles;
        step_bank = b;
        fx = fx_t'(b / `DRV_N_FY);
        fy = fy_t'(b % `DRV_N_FY);
        base_addr = bank_base[b];
        start = 1'b1;
        starts_issued++;
        @(negedge clk);
        start = 1'b0;
        cycles = 0;
        while (!ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > 16) begin
                abort_run("timeout while waiting for ready");
            end
        end
        repeat (3) @(negedge clk);
    endtask

    function automatic int random_bank();
        int v;
        v = int'(random_line(3));
        return v % N_BANKS;
    endfunction

    initial begin
        arst_n_in = 1'b0;
        load_en = 1'b0;
        load_fx = '0;
        load_fy = '0;
        load_half = 1'b0;
        masks_in = '0;
        load_data = '0;
        start = 1'b0;
        clear_counters = 1'b0;
        fx = '0;
        fy = '0;
        base_addr = '0;
        for (int b = 0; b < N_BANKS; b++) begin
            bank_base[b] = addr_t'(16 + b * 64);
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n_in = 1'b1;
        // Outputs stay quiet until the first start
        repeat (5) @(negedge clk);
        check_mask(mask_out, '0, "mask_out after reset");
        check_line(encoded_out, '0, "encoded_out after reset");

        clear_all();
        for (int b = 0; b < N_BANKS; b++) begin
            load_bank(b, b == 0);
        end
        run_step(0);
        for (int s = 0; s < 48; s++) begin
            run_step(random_bank());
        end
        // Drain one bank past its last mask
        for (int s = 0; s < DEPTH + 2; s++) begin
            run_step(N_BANKS - 1);
        end
        check_mask(mask_out, '0, "mask_out of a drained bank");
        check_line(encoded_out, '0, "encoded_out of a drained bank");

        clear_all();
        for (int b = 0; b < N_BANKS; b++) begin
            load_bank(b, 1'b1);
        end
        for (int b = 0; b < N_BANKS; b++) begin
            run_step(b);
        end
        for (int s = 0; s < 36; s++) begin
            run_step(random_bank());
        end

        if (u_sparse_act_driver.u_driver_ctrl.u_driver_ctrl_sva.fail_count != 0) begin
            abort_run("controller assertions failed");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/driver_pkg.sv
hdl/mask_store.sv
hdl/encoded_store.sv
hdl/act_compactor.sv
hdl/driver_ctrl.sv
hdl/sparse_act_driver.sv
sim/sparse_act_driver_sva.sv
sim/tb_sparse_act_driver.sv

//--- Bender.yml
package:
  name: sparse_act_driver

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/driver_pkg.sv
      - hdl/mask_store.sv
      - hdl/encoded_store.sv
      - hdl/act_compactor.sv
      - hdl/driver_ctrl.sv
      - hdl/sparse_act_driver.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/sparse_act_driver_sva.sv
      - sim/tb_sparse_act_driver.sv
